//--- verilog.f
+incdir+logic
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/r_decoder.sv
logic/i_decoder.sv
logic/d_decoder.sv
logic/b_decoder.sv
logic/control_unit.sv
verif/control_unit_checker.sv
verif/control_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= control_unit_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := verilog.f $(wildcard logic/*.sv logic/*.svh verif/*.sv)
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f verilog.f -Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/control_unit_tb.sv
`include "cpu_ctrl_macros.svh"

module control_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ctrl_pkg::*;

    // Legal instructions before the final illegal one
    localparam int NUM_INSTR = 68;
    localparam int CLK_HALF = 2;
    // Three cycles per instruction, reset, and a margin
    localparam int WATCHDOG_NS = (3 * (NUM_INSTR + 1) + 10 + 40) * 2 * CLK_HALF;

    logic                 clk;
    logic                 rst_n;
    logic [`INSTR_W-1:0]  instr;
    logic [`STATUS_W-1:0] status;
    logic [`CW_W-1:0]     cw;
    logic [`DATA_W-1:0]   k;
    logic                 ir_load;
    logic                 halted;

    // Shadow machine for the expected values
    state_t              m_state;
    logic [`INSTR_W-1:0] m_ir;
    logic [`CW_W-1:0]    exp_cw;
    logic [`DATA_W-1:0]  exp_k;
    logic [31:0]         rng;
    int                  err_cw;
    int                  err_k;
    int                  err_ir_load;
    int                  err_halted;
    int                  err_checker;

    control_unit u_control_unit (
        .clk     (clk),
        .rst_n   (rst_n),
        .instr   (instr),
        .status  (status),
        .cw      (cw),
        .k       (k),
        .ir_load (ir_load),
        .halted  (halted)
    );

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Encoding of opcode number sel with random fields from r
    function automatic logic [31:0] make_instr(int sel, logic [31:0] r);
        logic [3:0] cond;
        case (r[31:30])
            2'd0: cond = 4'h0;
            2'd1: cond = 4'h1;
            2'd2: cond = 4'ha;
            default: cond = 4'hb;
        endcase
        case (sel)
            0: return {11'b10001010000, r[20:0]};
            1: return {11'b10101010000, r[20:0]};
            2: return {11'b10001011000, r[20:0]};
            3: return {11'b10101011000, r[20:0]};
            4: return {11'b11001010000, r[20:0]};
            5: return {11'b11001011000, r[20:0]};
            6: return {11'b11101011000, r[20:0]};
            7: return {11'b11010011011, r[20:0]};
            8: return {11'b11010011010, r[20:0]};
            9: return {10'b1001000100, r[21:0]};
            10: return {10'b1101000100, r[21:0]};
            11: return {11'b11111000010, r[20:0]};
            12: return {11'b11111000000, r[20:0]};
            13: return {6'b000101, r[25:0]};
            14: return {6'b100101, r[25:0]};
            15: return {8'b01010100, r[23:4], cond};
            default: return {8'b10110100, r[23:0]};
        endcase
    endfunction

    // Expected {cw, k} from the decoding rules
    function automatic logic [`CW_W+`DATA_W-1:0] model_word(state_t st, logic [31:0] ir,
                                                         logic [4:0] sf);
        logic        alu_en, alu_bs, rf_b_en, rf_w, ram_en, ram_w, pc_en, status_ld;
        logic        exec, taken, is_bl;
        logic [4:0]  alu_fs, rf_sa, rf_sb, rf_da;
        logic [1:0]  pc_fs, ns;
        logic [10:0] op;
        logic [63:0] kk;
        {alu_en, alu_bs, rf_b_en, rf_w, ram_en, ram_w, pc_en, status_ld} = '0;
        {alu_fs, rf_sa, rf_sb, rf_da, pc_fs, ns} = '0;
        kk = '0;
        taken = 1'b0;
        op = ir[31:21];
        exec = (st == st_exec);
        is_bl = (ir[31:26] == 6'b100101);
        if (st == st_fetch) begin
            ram_en = 1'b1;
            pc_en = 1'b1;
            pc_fs = 2'd1;
            ns = 2'd1;
        end else if (st == st_halt) begin
            ns = 2'd3;
        end else if (op inside {11'b10001010000, 11'b10101010000, 11'b10001011000,
                                11'b10101011000, 11'b11001010000, 11'b11001011000,
                                11'b11101011000, 11'b11010011011, 11'b11010011010}) begin
            // R format
            alu_en = 1'b1;
            case (op)
                11'b10001010000: alu_fs = 5'b00000;
                11'b10101010000: alu_fs = 5'b00100;
                11'b11001010000: alu_fs = 5'b01100;
                11'b11001011000, 11'b11101011000: alu_fs = 5'b01010;
                11'b11010011011: alu_fs = 5'b10000;
                11'b11010011010: alu_fs = 5'b10100;
                default: alu_fs = 5'b01000;
            endcase
            rf_sa = ir[9:5];
            rf_sb = ir[20:16];
            rf_da = ir[4:0];
            rf_w = exec;
            status_ld = exec && (op inside {11'b10101011000, 11'b11101011000});
            kk = {58'b0, ir[15:10]};
        end else if (ir[31:22] inside {10'b1001000100, 10'b1101000100}) begin
            // Immediate arithmetic, SUBI inverts B
            alu_en = 1'b1;
            alu_bs = 1'b1;
            alu_fs = ir[30] ? 5'b01010 : 5'b01000;
            rf_sa = ir[9:5];
            rf_da = ir[4:0];
            rf_w = exec;
            kk = {52'b0, ir[21:10]};
        end else if (op inside {11'b11111000010, 11'b11111000000}) begin
            // Load and store, address then memory
            alu_bs = 1'b1;
            alu_fs = 5'b01000;
            rf_sa = ir[9:5];
            kk = {{55{ir[20]}}, ir[20:12]};
            if (exec) begin
                ns = 2'd2;
            end else if (op[1]) begin
                ram_en = 1'b1;
                rf_w = 1'b1;
                rf_da = ir[4:0];
            end else begin
                ram_w = 1'b1;
                rf_b_en = 1'b1;
                rf_sb = ir[4:0];
            end
        end else if (ir[31:26] inside {6'b000101, 6'b100101} ||
                     ir[31:24] inside {8'b01010100, 8'b10110100}) begin
            if (ir[31:24] == 8'b10110100) begin
                taken = sf[4];
            end else if (ir[31:24] == 8'b01010100) begin
                case (ir[3:0])
                    4'h0: taken = sf[0];
                    4'h1: taken = !sf[0];
                    4'ha: taken = (sf[1] == sf[3]);
                    4'hb: taken = (sf[1] != sf[3]);
                    default: taken = 1'b0;
                endcase
            end else begin
                taken = 1'b1;
            end
            taken = taken && exec;
            pc_fs = taken ? 2'd2 : 2'd0;
            // Link register X30
            rf_da = is_bl ? 5'd30 : 5'd0;
            rf_w = is_bl && taken;
            pc_en = is_bl;
            if (ir[31:26] inside {6'b000101, 6'b100101}) begin
                kk = {{36{ir[25]}}, ir[25:0], 2'b00};
            end else begin
                kk = {{43{ir[23]}}, ir[23:5], 2'b00};
            end
        end else begin
            ns = 2'd3;
        end
        return {alu_en, alu_bs, alu_fs, rf_b_en, rf_sa, rf_sb, rf_da, rf_w, ram_en, ram_w,
                pc_en, pc_fs, 1'b0, status_ld, ns, kk};
    endfunction

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always_comb begin
        {exp_cw, exp_k} = model_word(m_state, m_ir, status);
    end

    // Shadow state follows its own next_state field
    always @(posedge clk) begin
        if (!rst_n) begin
            m_state <= st_fetch;
        end else begin
            if (m_state == st_fetch) begin
                m_ir <= instr;
            end
            m_state <= state_t'(exp_cw[1:0]);
        end
    end

    // Outputs settled mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            assert (cw === exp_cw) else begin
                $display("FAIL cw: got %h expected %h", cw, exp_cw);
                err_cw++;
            end
            assert (k === exp_k) else begin
                $display("FAIL k: got %h expected %h", k, exp_k);
                err_k++;
            end
            assert (ir_load === (m_state == st_fetch)) else begin
                $display("FAIL ir_load: got %h expected %h", ir_load, m_state == st_fetch);
                err_ir_load++;
            end
            assert (halted === (m_state == st_halt)) else begin
                $display("FAIL halted: got %h expected %h", halted, m_state == st_halt);
                err_halted++;
            end
        end
    end

    initial begin
        #WATCHDOG_NS;
        $display("Timeout: the instruction sequence did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        instr = '0;
        status = '0;
        m_ir = '0;
        rng = 32'h288c;
        {err_cw, err_k, err_ir_load, err_halted} = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_INSTR; i++) begin
            rng = xorshift(rng);
            // Every opcode comes up several times
            instr = make_instr(i % 17, rng);
            do begin
                @(posedge clk);
                #1;
                rng = xorshift(rng);
                status = rng[4:0];
            end while (!ir_load);
        end
        // Opcode zero belongs to no format
        instr = 32'h0;
        repeat (12) begin
            @(posedge clk);
            #1;
            rng = xorshift(rng);
            status = rng[4:0];
        end
        err_checker = u_control_unit.u_checker.fail_reset + u_control_unit.u_checker.fail_pulse
                    + u_control_unit.u_checker.fail_mem + u_control_unit.u_checker.fail_stop
                    + u_control_unit.u_checker.fail_halt;
        $display("Errors: cw=%0d k=%0d ir_load=%0d halted=%0d checker=%0d",
                 err_cw, err_k, err_ir_load, err_halted, err_checker);
        if (err_cw + err_k + err_ir_load + err_halted + err_checker == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verif/control_unit_checker.sv
`include "cpu_ctrl_macros.svh"

module control_unit_checker (
    input logic                clk,
    input logic                rst_n,
    input logic [`INSTR_W-1:0] instr,
    input logic [`CW_W-1:0]    cw,
    input logic                ir_load,
    input logic                halted
);
    timeunit 1ns;
    timeprecision 100ps;

    // RAM read, PC plus 4, next state exec
    localparam logic [`CW_W-1:0] FETCH_CW = 33'h151;
    localparam logic [`CW_W-1:0] HALT_CW = 33'h3;

    // Failures per property, summed by the testbench
    int fail_reset = 0;
    int fail_pulse = 0;
    int fail_mem = 0;
    int fail_stop = 0;
    int fail_halt = 0;

    // First cycle out of reset fetches
    a_reset_fetch: assert property (@(posedge clk) $rose(rst_n) |-> ir_load && cw == FETCH_CW)
        else begin
            $error("no fetch word in the first cycle after reset");
            fail_reset++;
        end

    // Fetch lasts one cycle
    a_load_pulse: assert property (@(posedge clk) disable iff (!rst_n) ir_load |=> !ir_load)
        else begin
            $error("ir_load held for more than one cycle");
            fail_pulse++;
        end

    // Address cycle, memory cycle, then fetch again
    a_mem_then_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        (!ir_load && !halted && cw[1:0] == 2'd2) |=> !ir_load ##1 ir_load)
        else begin
            $error("load or store did not return to fetch after its memory cycle");
            fail_mem++;
        end

    // Opcode zero fits no format
    // Exec gives the halt word, halted follows one cycle later
    a_illegal_stops: assert property (@(posedge clk) disable iff (!rst_n)
        (ir_load && instr[`INSTR_W-1:`INSTR_W-11] == 11'b0)
        |=> (cw == HALT_CW && !halted) ##1 halted)
        else begin
            $error("illegal opcode did not halt the cycle after its exec");
            fail_stop++;
        end

    // Stuck in halt until reset
    a_halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted && cw == HALT_CW && !ir_load)
        else begin
            $error("machine left halt without a reset");
            fail_halt++;
        end

endmodule

bind control_unit control_unit_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .instr   (instr),
    .cw      (cw),
    .ir_load (ir_load),
    .halted  (halted)
);

//--- logic/control_unit.sv
`include "cpu_ctrl_macros.svh"

module control_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`INSTR_W-1:0]  instr,
    input  logic [`STATUS_W-1:0] status,
    output logic [`CW_W-1:0]     cw,
    output logic [`DATA_W-1:0]   k,
    output logic                 ir_load,
    output logic                 halted
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    // RAM onto the bus at PC, PC plus 4, then execute
    localparam logic [`CW_W-1:0] FETCH_CW = {7'b0, 1'b0, 15'b0, 1'b0, 1'b1, 1'b0,
                                             1'b1, pc_inc4, 1'b0, 1'b0, st_exec};
    // Everything off, stay halted
    localparam logic [`CW_W-1:0] HALT_CW = {31'b0, st_halt};

    state_t              state_q;
    logic [`INSTR_W-1:0] ir_q;
    logic [10:0]         op;
    format_t             fmt;
    logic [`CW_W-1:0]    r_cw, i_cw, d_cw, b_cw;
    logic [`DATA_W-1:0]  r_k, i_k, d_k, b_k;

    // Next state is carried in the low bits of cw
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_fetch;
        end else begin
            state_q <= state_t'(cw[1:0]);
        end
    end

    // Instruction register, loaded in fetch
    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir_q <= instr;
        end
    end

    assign ir_load = rst_n && (state_q == st_fetch);
    assign halted  = (state_q == st_halt);

    // Format from the latched opcode
    assign op = ir_q[31:21];

    always_comb begin
        case (op)
            op_and, op_orr, op_add, op_adds, op_eor,
            op_sub, op_subs, op_lsl, op_lsr: fmt = fmt_r;
            op_ldur, op_stur:                fmt = fmt_d;
            default:                         fmt = fmt_illegal;
        endcase
        // 10-bit immediate opcodes
        if (ir_q[31:22] == 10'(op_addi >> 1) || ir_q[31:22] == 10'(op_subi >> 1)) begin
            fmt = fmt_i;
        end
        // 6-bit and 8-bit branch opcodes
        if (ir_q[31:26] == 6'(op_b >> 5) || ir_q[31:26] == 6'(op_bl >> 5) ||
            ir_q[31:24] == 8'(op_b_cond >> 3) || ir_q[31:24] == 8'(op_cbz >> 3)) begin
            fmt = fmt_b;
        end
    end

    // Format decoders side by side
    r_decoder u_r_decoder (.instr(ir_q), .state(state_q), .cw(r_cw), .k(r_k));
    i_decoder u_i_decoder (.instr(ir_q), .state(state_q), .cw(i_cw), .k(i_k));
    d_decoder u_d_decoder (.instr(ir_q), .state(state_q), .cw(d_cw), .k(d_k));
    b_decoder u_b_decoder (
        .instr  (ir_q),
        .state  (state_q),
        .status (status),
        .cw     (b_cw),
        .k      (b_k)
    );

    // Fetch and halt words local, exec and mem from the decoder
    always_comb begin
        k = '0;
        case (state_q)
            st_fetch: cw = FETCH_CW;
            st_halt:  cw = HALT_CW;
            default: begin
                case (fmt)
                    fmt_r: begin
                        cw = r_cw;
                        k  = r_k;
                    end
                    fmt_i: begin
                        cw = i_cw;
                        k  = i_k;
                    end
                    fmt_d: begin
                        cw = d_cw;
                        k  = d_k;
                    end
                    fmt_b: begin
                        cw = b_cw;
                        k  = b_k;
                    end
                    // Unknown opcode stops the machine
                    default: cw = HALT_CW;
                endcase
            end
        endcase
    end

endmodule

//--- logic/b_decoder.sv
`include "cpu_ctrl_macros.svh"

module b_decoder (
    input  logic [`INSTR_W-1:0]  instr,
    input  ctrl_pkg::state_t     state,
    input  logic [`STATUS_W-1:0] status,
    output logic [`CW_W-1:0]     cw,
    output logic [`DATA_W-1:0]   k
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    // Link register for BL
    localparam logic [`REG_W-1:0] LINK_REG = 30;

    logic [25:0]       imm26;
    logic [18:0]       imm19;
    logic [3:0]        cond;
    logic              is_b;
    logic              is_bl;
    logic              is_cbz;
    logic              cond_ok;
    logic              taken;
    pc_fn_t            pc_fs;

    assign imm26 = instr[25:0];
    assign imm19 = instr[23:5];
    assign cond  = instr[3:0];

    // Short opcodes compared on their leading bits
    assign is_b   = (instr[31:26] == 6'(op_b >> 5));
    assign is_bl  = (instr[31:26] == 6'(op_bl >> 5));
    assign is_cbz = (instr[31:24] == 8'(op_cbz >> 3));

    // Flags: Z=0, N=1, C=2, V=3, operand zero=4
    always_comb begin
        if (is_b || is_bl) begin
            cond_ok = 1'b1;
        end else if (is_cbz) begin
            cond_ok = status[4];
        end else begin
            case (cond)
                cond_eq: cond_ok = status[0];
                cond_ne: cond_ok = !status[0];
                cond_lt: cond_ok = (status[1] != status[3]);
                cond_ge: cond_ok = (status[1] == status[3]);
                default: cond_ok = 1'b0;
            endcase
        end
    end

    // PC moves only from the execute cycle
    assign taken = cond_ok && (state == st_exec);
    assign pc_fs = taken ? pc_add_k : pc_hold;

    // BL puts the PC on the bus and writes X30
    assign cw = {1'b0, 1'b0, alu_and, 1'b0, {`REG_W{1'b0}}, {`REG_W{1'b0}},
                 is_bl ? LINK_REG : {`REG_W{1'b0}}, is_bl && taken,
                 1'b0, 1'b0, is_bl, pc_fs, 1'b0, 1'b0, st_fetch};

    // Word offsets, sign extended
    assign k = (is_b || is_bl) ? {{(`DATA_W - 28){imm26[25]}}, imm26, 2'b00}
                               : {{(`DATA_W - 21){imm19[18]}}, imm19, 2'b00};

endmodule

//--- logic/d_decoder.sv
`include "cpu_ctrl_macros.svh"

module d_decoder (
    input  logic [`INSTR_W-1:0] instr,
    input  ctrl_pkg::state_t    state,
    output logic [`CW_W-1:0]    cw,
    output logic [`DATA_W-1:0]  k
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [10:0]       op;
    logic [8:0]        offset;
    logic [`REG_W-1:0] rn;
    logic [`REG_W-1:0] rt;
    logic              is_load;

    // Bits 11:10 between the offset and Rn are not decoded
    assign op     = instr[31:21];
    assign offset = instr[20:12];
    assign rn     = instr[9:5];
    assign rt     = instr[4:0];

    assign is_load = (op == op_ldur);

    always_comb begin
        case (state)
            st_mem: begin
                // Address stays on the ALU, K into operand B
                if (is_load) begin
                    // RAM onto the bus, written to Rt
                    cw = {1'b0, 1'b1, alu_add, 1'b0, rn, {`REG_W{1'b0}}, rt, 1'b1,
                          1'b1, 1'b0, 1'b0, pc_hold, 1'b0, 1'b0, st_fetch};
                end else begin
                    // Rt onto the bus, RAM write
                    cw = {1'b0, 1'b1, alu_add, 1'b1, rn, rt, {`REG_W{1'b0}}, 1'b0,
                          1'b0, 1'b1, 1'b0, pc_hold, 1'b0, 1'b0, st_fetch};
                end
            end
            default: begin
                // Address cycle, Rn plus offset
                cw = {1'b0, 1'b1, alu_add, 1'b0, rn, {`REG_W{1'b0}}, {`REG_W{1'b0}},
                      1'b0, 1'b0, 1'b0, 1'b0, pc_hold, 1'b0, 1'b0, st_mem};
            end
        endcase
    end

    // Signed 9-bit byte offset
    assign k = {{(`DATA_W - 9){offset[8]}}, offset};

endmodule

//--- logic/i_decoder.sv
`include "cpu_ctrl_macros.svh"

module i_decoder (
    input  logic [`INSTR_W-1:0] instr,
    input  ctrl_pkg::state_t    state,
    output logic [`CW_W-1:0]    cw,
    output logic [`DATA_W-1:0]  k
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [9:0]        op;
    logic [11:0]       imm12;
    logic [`REG_W-1:0] rn;
    logic [`REG_W-1:0] rd;
    alu_fn_t           alu_fs;
    logic              exec;

    assign {op, imm12, rn, rd} = instr;

    // Write back only in the execute cycle
    assign exec = (state == st_exec);

    // SUBI inverts K, anything else adds
    assign alu_fs = (op == 10'(op_subi >> 1)) ? alu_sub : alu_add;

    // Operand B comes from K, so rf_sb stays zero
    // No flag update for the immediate forms
    assign cw = {1'b1, 1'b1, alu_fs, 1'b0, rn, {`REG_W{1'b0}}, rd, exec,
                 1'b0, 1'b0, 1'b0, pc_hold, 1'b0, 1'b0, st_fetch};

    // Unsigned 12-bit immediate
    assign k = {{(`DATA_W - 12){1'b0}}, imm12};

endmodule

//--- logic/r_decoder.sv
`include "cpu_ctrl_macros.svh"

module r_decoder (
    input  logic [`INSTR_W-1:0] instr,
    input  ctrl_pkg::state_t    state,
    output logic [`CW_W-1:0]    cw,
    output logic [`DATA_W-1:0]  k
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic [10:0]       op;
    logic [`REG_W-1:0] rm;
    logic [5:0]        shamt;
    logic [`REG_W-1:0] rn;
    logic [`REG_W-1:0] rd;
    alu_fn_t           alu_fs;
    logic              exec;
    logic              sets_flags;

    assign {op, rm, shamt, rn, rd} = instr;

    // Register writes only while executing
    assign exec = (state == st_exec);

    // Opcode to ALU function
    always_comb begin
        case (op)
            op_and:          alu_fs = alu_and;
            op_orr:          alu_fs = alu_or;
            op_eor:          alu_fs = alu_xor;
            op_add, op_adds: alu_fs = alu_add;
            op_sub, op_subs: alu_fs = alu_sub;
            op_lsl:          alu_fs = alu_lsl;
            op_lsr:          alu_fs = alu_lsr;
            default:         alu_fs = alu_and;
        endcase
    end

    // Only the S forms update flags
    assign sets_flags = (op == op_adds) || (op == op_subs);

    // ALU drives the bus, operand B from Rm
    assign cw = {1'b1, 1'b0, alu_fs, 1'b0, rn, rm, rd, exec,
                 1'b0, 1'b0, 1'b0, pc_hold, 1'b0, sets_flags && exec, st_fetch};

    // Shift amount for LSL and LSR
    assign k = {{(`DATA_W - 6){1'b0}}, shamt};

endmodule

//--- logic/ctrl_pkg.sv
package ctrl_pkg;

    // Encoding doubles as the next_state field of the control word
    typedef enum logic [1:0] {
        st_fetch = 2'd0,
        st_exec  = 2'd1,
        st_mem   = 2'd2,
        st_halt  = 2'd3
    } state_t;

    // FS[4:2] picks the operation
    // FS[1] inverts operand B, FS[0] inverts operand A
    typedef enum logic [4:0] {
        alu_and = 5'b00000,
        alu_or  = 5'b00100,
        alu_add = 5'b01000,
        alu_sub = 5'b01010,
        alu_xor = 5'b01100,
        alu_lsl = 5'b10000,
        alu_lsr = 5'b10100
    } alu_fn_t;

    // Program counter update
    typedef enum logic [1:0] {
        pc_hold  = 2'd0,
        pc_inc4  = 2'd1,
        pc_add_k = 2'd2,
        pc_load  = 2'd3
    } pc_fn_t;

endpackage

//--- logic/isa_pkg.sv
package isa_pkg;

    // Decoder selected for a latched instruction
    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_d,
        fmt_b,
        fmt_illegal
    } format_t;

    // Major opcodes, left aligned in instr[31:21]
    // I format compares the leading 10 bits
    // B and BL compare the leading 6 bits
    // B.cond and CBZ compare the leading 8 bits
    // Unused trailing bits are zero
    typedef enum logic [10:0] {
        op_and    = 11'b10001010000,
        op_orr    = 11'b10101010000,
        op_add    = 11'b10001011000,
        op_adds   = 11'b10101011000,
        op_eor    = 11'b11001010000,
        op_sub    = 11'b11001011000,
        op_subs   = 11'b11101011000,
        op_lsl    = 11'b11010011011,
        op_lsr    = 11'b11010011010,
        op_addi   = 11'b10010001000,
        op_subi   = 11'b11010001000,
        op_ldur   = 11'b11111000010,
        op_stur   = 11'b11111000000,
        op_b      = 11'b00010100000,
        op_bl     = 11'b10010100000,
        op_b_cond = 11'b01010100000,
        op_cbz    = 11'b10110100000
    } opcode_t;

    // B.cond condition field, instr[3:0]
    typedef enum logic [3:0] {
        cond_eq = 4'h0,
        cond_ne = 4'h1,
        cond_ge = 4'ha,
        cond_lt = 4'hb
    } cond_t;

endpackage

//--- logic/cpu_ctrl_macros.svh
`ifndef CPU_CTRL_MACROS_SVH
`define CPU_CTRL_MACROS_SVH

// Fetched instruction word
`define INSTR_W 32
// Packed control word, 15 fields
`define CW_W 33
// Data bus and constant K
`define DATA_W 64
// Flags from the datapath
`define STATUS_W 5
// Register file address
`define REG_W 5

`endif
